// File: sync_meter.f
hdl/raster_pkg.sv
hdl/meas_pkg.sv
hdl/video_timing_gen.sv
hdl/sync_blank_counter.sv
hdl/video_counter.sv
hdl/sync_meter_top.sv
testbench/sync_meter_props.sv
testbench/sync_meter_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the sync meter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module sync_meter_tb \
    -Mdir obj_dir \
    -f sync_meter.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vsync_meter_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation did not report a pass"
exit 1

// File: testbench/sync_meter_tb.sv
`default_nettype none

module sync_meter_tb;
    import raster_pkg::*;
    import meas_pkg::*;

    localparam int clk_period    = 20;
    localparam int drive_dly     = 2;                   // Inputs move just after the edge
    localparam int n_random      = 5;                   // Random configurations
    localparam int n_frames      = 3 + 2 + 2 + 2 * n_random + 1;
    localparam int frame_cyc_max = 4 * 342 * 29;        // Longest line by tallest frame, gap margin
    localparam int wait_cyc_max  = frame_cyc_max;       // One frame at most between vs rises
    localparam int watchdog_time = n_frames * frame_cyc_max * 2 * clk_period;

    logic        clk = 1'b0;
    logic        rst;
    logic        pxl_cen;
    logic        flip;
    axis_cfg_t   h_cfg;
    axis_cfg_t   v_cfg;
    video_sync_t raster;
    logic        rdy;
    axis_meas_t  h_meas;
    axis_meas_t  v_meas;

    logic        cen_random;                            // pxl_cen from the LFSR when set
    logic        rdy_seen;                              // rdy must hold from here on
    logic [31:0] lfsr_q;

    always #(clk_period / 2) clk = ~clk;

    sync_meter_top sync_meter_top_i (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .flip    (flip),
        .h_cfg   (h_cfg),
        .v_cfg   (v_cfg),
        .raster  (raster),
        .rdy     (rdy),
        .h_meas  (h_meas),
        .v_meas  (v_meas)
    );

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};            // One step per bit
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic axis_cfg_t make_cfg(px_cnt_t a, len_t f, len_t s, len_t b);
        axis_cfg_t c;
        c.active = a;
        c.front  = f;
        c.sync   = s;
        c.back   = b;
        return c;
    endfunction

    // Reference values straight from the axis timing
    function automatic axis_meas_t expect_meas(axis_cfg_t c, logic flipped);
        axis_meas_t e;
        e.total  = (c.active - 9'd1) ^ {1'b0, {8{flipped}}};   // Low byte mirrored when flipped
        e.bs_len = c.front;
        e.sy_len = c.sync;
        e.sa_len = c.back;
        return e;
    endfunction

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, name, act, exp);
            stop_run();
        end
    endtask

    task automatic check_sync(input string name, input video_sync_t act, input video_sync_t exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b (lhbl lvbl hs vs)",
                     $time, name, act, exp);
            stop_run();
        end
    endtask

    task automatic check_meas(input string name, input axis_meas_t act, input axis_meas_t exp);
        if (act !== exp) begin
            $write("** Error at %0t: %s is total %0d bs %0d sy %0d sa %0d,",
                   $time, name, act.total, act.bs_len, act.sy_len, act.sa_len);
            $display(" expected total %0d bs %0d sy %0d sa %0d",
                     exp.total, exp.bs_len, exp.sy_len, exp.sa_len);
            stop_run();
        end
    endtask

    // One clock, then the outputs are checked and pxl_cen is driven
    task automatic tick();
        logic        cen_edge;
        video_sync_t raster_last;
        logic [31:0] r;
        cen_edge    = pxl_cen;                          // Enable seen by the coming edge
        raster_last = raster;
        @(posedge clk);
        #drive_dly;
        if (!cen_edge && !rst) begin
            check_sync("raster while pxl_cen low", raster, raster_last);   // Must freeze
        end
        if (rdy_seen) begin
            check_bit("rdy", rdy, 1'b1);                // Sticky until reset
        end
        if (cen_random) begin
            take_bits(1, r);
            pxl_cen = r[0];
        end else begin
            pxl_cen = 1'b1;
        end
    endtask

    task automatic wait_vs_rise();
        logic vs_prev;
        logic seen;
        int   n;
        vs_prev = raster.vs;
        seen    = 1'b0;
        n       = 0;
        while (!seen && n < wait_cyc_max) begin
            tick();
            n++;
            seen    = raster.vs && !vs_prev;
            vs_prev = raster.vs;
        end
        if (!seen) begin
            $display("Timeout: raster.vs did not rise within %0d clock cycles", wait_cyc_max);
            stop_run();
        end
    endtask

    task automatic check_idle();
        check_sync("raster", raster, '0);
        check_bit("rdy", rdy, 1'b0);
        check_meas("h_meas", h_meas, '0);
        check_meas("v_meas", v_meas, '0);
    endtask

    task automatic test_reset();
        int i;
        rst = 1'b1;
        for (i = 0; i < 3; i++) begin                   // Three cycles in reset
            tick();
            check_idle();
        end
        rst = 1'b0;
        tick();                                         // Still in the front porch
        check_idle();
    endtask

    task automatic test_ready();
        int i;
        for (i = 1; i <= 3; i++) begin
            wait_vs_rise();
            if (i < 3) begin
                check_bit("rdy", rdy, 1'b0);            // Fewer than two frame ends so far
            end
        end
        check_bit("rdy", rdy, 1'b1);
        rdy_seen = 1'b1;
    endtask

    task automatic test_basic();
        check_meas("h_meas", h_meas, expect_meas(h_cfg, flip));
        check_meas("v_meas", v_meas, expect_meas(v_cfg, flip));
    endtask

    task automatic test_flip();
        flip = 1'b1;
        wait_vs_rise();
        wait_vs_rise();                                 // Vertical total lands in between
        check_meas("h_meas flipped", h_meas, expect_meas(h_cfg, 1'b1));
        check_meas("v_meas flipped", v_meas, expect_meas(v_cfg, 1'b1));
    endtask

    task automatic test_reconfig();
        h_cfg = make_cfg(9'd300, 6'd10, 6'd12, 6'd20);  // Total above 255, flip still set
        v_cfg = make_cfg(9'd5, 6'd1, 6'd1, 6'd2);
        wait_vs_rise();
        wait_vs_rise();
        check_meas("h_meas reconfig", h_meas, expect_meas(h_cfg, flip));
        check_meas("v_meas reconfig", v_meas, expect_meas(v_cfg, flip));
    endtask

    task automatic test_random();
        axis_cfg_t   h_rnd;
        axis_cfg_t   v_rnd;
        logic [31:0] r;
        int          i;
        cen_random = 1'b1;                              // Gaps on pxl_cen
        for (i = 0; i < n_random; i++) begin
            take_bits(5, r);
            h_rnd.active = 9'd4 + {4'd0, r[4:0]};
            take_bits(3, r);
            h_rnd.front  = 6'd1 + {3'd0, r[2:0]};
            take_bits(3, r);
            h_rnd.sync   = 6'd1 + {3'd0, r[2:0]};
            take_bits(3, r);
            h_rnd.back   = 6'd1 + {3'd0, r[2:0]};
            take_bits(4, r);
            v_rnd.active = 9'd2 + {5'd0, r[3:0]};
            take_bits(2, r);
            v_rnd.front  = 6'd1 + {4'd0, r[1:0]};
            take_bits(2, r);
            v_rnd.sync   = 6'd1 + {4'd0, r[1:0]};
            take_bits(2, r);
            v_rnd.back   = 6'd1 + {4'd0, r[1:0]};
            take_bits(1, r);
            flip  = r[0];
            h_cfg = h_rnd;                              // Applied during vertical sync
            v_cfg = v_rnd;
            wait_vs_rise();
            wait_vs_rise();
            check_meas("h_meas random", h_meas, expect_meas(h_rnd, flip));
            check_meas("v_meas random", v_meas, expect_meas(v_rnd, flip));
        end
        cen_random = 1'b0;
    endtask

    initial begin
        rst        = 1'b1;
        pxl_cen    = 1'b1;
        flip       = 1'b0;
        cen_random = 1'b0;
        rdy_seen   = 1'b0;
        lfsr_q     = 32'hbc23404a;
        h_cfg      = make_cfg(9'd16, 6'd3, 6'd4, 6'd5);  // Small default raster
        v_cfg      = make_cfg(9'd6, 6'd2, 6'd3, 6'd4);
        test_reset();
        test_ready();
        test_basic();
        test_flip();
        test_reconfig();
        test_random();
        $display("Test OK");
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("Watchdog: the run took longer than its time limit");
        stop_run();
    end

endmodule

`default_nettype wire

// File: testbench/sync_meter_props.sv
`default_nettype none

module sync_meter_props (
    input wire logic                    clk,
    input wire logic                    rst,
    input wire raster_pkg::video_sync_t raster,
    input wire logic                    rdy
);

    // Horizontal sync sits inside horizontal blanking
    hs_in_blank: assert property (@(posedge clk) disable iff (rst)
        raster.hs |-> !raster.lhbl)
        else $error("hs is high while lhbl is high");

    // Vertical sync sits inside vertical blanking
    vs_in_blank: assert property (@(posedge clk) disable iff (rst)
        raster.vs |-> !raster.lvbl)
        else $error("vs is high while lvbl is high");

    // Once set, only reset clears ready
    rdy_sticky: assert property (@(posedge clk) disable iff (rst)
        ($past(rdy) && !$past(rst)) |-> rdy)
        else $error("rdy fell without reset");

    // Vertical level moves only with the line step
    lvbl_on_line: assert property (@(posedge clk) disable iff (rst)
        $changed(raster.lvbl) |-> $fell(raster.lhbl))
        else $error("lvbl changed without a falling lhbl");

endmodule

bind sync_meter_top sync_meter_props sync_meter_props_i (
    .clk    (clk),
    .rst    (rst),
    .raster (raster),
    .rdy    (rdy)
);

`default_nettype wire

// File: hdl/sync_meter_top.sv
`default_nettype none

module sync_meter_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   pxl_cen,   // Pixel clock enable
    input  wire logic                   flip,      // Mirror measured totals
    input  wire raster_pkg::axis_cfg_t  h_cfg,     // Horizontal timing
    input  wire raster_pkg::axis_cfg_t  v_cfg,     // Vertical timing
    output raster_pkg::video_sync_t     raster,    // Generated levels
    output logic                        rdy,       // Measurements valid
    output meas_pkg::axis_meas_t        h_meas,    // Horizontal result
    output meas_pkg::axis_meas_t        v_meas     // Vertical result
);

    // Producer, raster also leaves the top unchanged
    video_timing_gen video_timing_gen_i (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .h_cfg   (h_cfg),
        .v_cfg   (v_cfg),
        .raster  (raster)
    );

    // Consumer, fed straight from the generator
    video_counter video_counter_i (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .flip    (flip),
        .raster  (raster),
        .rdy     (rdy),
        .h_meas  (h_meas),
        .v_meas  (v_meas)
    );

endmodule

`default_nettype wire

// File: hdl/video_counter.sv
`default_nettype none

module video_counter (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    pxl_cen,   // Pixel clock enable
    input  wire logic                    flip,      // Flipped screen
    input  wire raster_pkg::video_sync_t raster,    // Levels under measurement
    output logic                         rdy,       // Measurements settled
    output meas_pkg::axis_meas_t         h_meas,
    output meas_pkg::axis_meas_t         v_meas
);
    logic       lhbl_l;                  // lhbl at the previous enabled pixel
    logic       lvbl_l;                  // lvbl at the previous line strobe
    logic       hbl_neg;                 // Horizontal blank starts
    logic       vbl_neg;                 // Vertical blank starts
    logic       v_step;                  // Line strobe
    logic [1:0] rdy_sh;                  // One stage per frame seen

    assign hbl_neg = !raster.lhbl && lhbl_l;
    assign vbl_neg = !raster.lvbl && lvbl_l;
    assign v_step  = pxl_cen && hbl_neg;     // Vertical levels only move here
    assign rdy     = rdy_sh[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            lhbl_l <= 1'b0;
            lvbl_l <= 1'b0;
        end else if (pxl_cen) begin
            lhbl_l <= raster.lhbl;
            if (hbl_neg) begin
                lvbl_l <= raster.lvbl;
            end
        end
    end

    // A frame ends where both blankings start on the same pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_sh <= '0;
        end else if (v_step && vbl_neg) begin
            rdy_sh <= {rdy_sh[0], 1'b1};     // Sticks high until reset
        end
    end

    sync_blank_counter h_cnt_i (
        .clk     (clk),
        .rst     (rst),
        .step    (pxl_cen),
        .flip    (flip),
        .sync    (raster.hs),
        .blank_n (raster.lhbl),
        .meas    (h_meas)
    );

    sync_blank_counter v_cnt_i (
        .clk     (clk),
        .rst     (rst),
        .step    (v_step),
        .flip    (flip),
        .sync    (raster.vs),
        .blank_n (raster.lvbl),
        .meas    (v_meas)
    );

endmodule

`default_nettype wire

// File: hdl/sync_blank_counter.sv
`default_nettype none

module sync_blank_counter (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            step,      // One sample per position on this axis
    input  wire logic            flip,      // Mirror the reported total
    input  wire logic            sync,      // High during the sync pulse
    input  wire logic            blank_n,   // High during active positions
    output meas_pkg::axis_meas_t meas       // Registered measurement
);
    import raster_pkg::*;

    px_cnt_t cnt;                       // Active positions of the current period
    len_t    aux;                       // Blanked positions since the last edge
    logic    sync_l;                    // Sync level at the previous step
    logic    blank_n_l;                 // Blank level at the previous step
    logic    sync_rise;
    logic    sync_fall;
    logic    act_start;                 // First active position

    assign sync_rise = sync && !sync_l;
    assign sync_fall = !sync && sync_l;
    assign act_start = blank_n && !blank_n_l;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_l    <= 1'b0;
            blank_n_l <= 1'b0;
        end else if (step) begin
            sync_l    <= sync;
            blank_n_l <= blank_n;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            aux  <= '0;
            meas <= '0;
        end else if (step) begin
            if (!blank_n) begin
                if (sync_rise) begin
                    meas.bs_len <= aux;      // Front porch complete
                    aux         <= 6'd1;     // This step is the first sync position
                end else if (sync_fall) begin
                    meas.sy_len <= aux;      // Sync pulse complete
                    aux         <= 6'd1;     // First back porch position
                end else begin
                    aux <= aux + 6'd1;
                end
            end else if (act_start) begin
                meas.sa_len <= aux;          // Back porch complete
                meas.total  <= cnt ^ {1'b0, {8{flip}}};
                aux         <= '0;
                cnt         <= '0;           // Counts from zero, ends at active minus one
            end else begin
                cnt <= cnt + 9'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/video_timing_gen.sv
`default_nettype none

module video_timing_gen (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   pxl_cen,   // Pixel clock enable
    input  wire raster_pkg::axis_cfg_t  h_cfg,     // Horizontal timing request
    input  wire raster_pkg::axis_cfg_t  v_cfg,     // Vertical timing request
    output raster_pkg::video_sync_t     raster     // Registered blank and sync levels
);
    import raster_pkg::*;

    typedef enum logic [1:0] {
        ph_active,                     // Visible positions
        ph_front,                      // Blank before sync
        ph_sync,                       // Sync pulse
        ph_back                        // Blank after sync
    } phase_t;

    axis_cfg_t h_cfg_q;                // Horizontal timing of the running frame
    axis_cfg_t v_cfg_q;                // Vertical timing of the running frame
    phase_t    h_ph;
    phase_t    h_ph_nx;
    phase_t    v_ph;
    phase_t    v_ph_nx;
    px_cnt_t   h_pos;                  // Position inside the horizontal phase
    px_cnt_t   h_pos_nx;
    px_cnt_t   v_pos;                  // Line inside the vertical phase
    px_cnt_t   v_pos_nx;
    logic      h_end;                  // Last pixel of the horizontal phase
    logic      v_end;                  // Last line of the vertical phase
    logic      line_step;              // Horizontal machine leaves active
    logic      frame_wrap;             // Vertical machine enters the first active line

    // Last position index of a phase, so it compares directly with the counter
    function automatic px_cnt_t phase_last(phase_t ph, axis_cfg_t cfg);
        px_cnt_t len;
        case (ph)
            ph_active: len = cfg.active;
            ph_front:  len = px_cnt_t'(cfg.front);   // Zero extended
            ph_sync:   len = px_cnt_t'(cfg.sync);
            default:   len = px_cnt_t'(cfg.back);
        endcase
        return len - 9'd1;             // Fields are nonzero on a valid config
    endfunction

    function automatic phase_t phase_next(phase_t ph);
        case (ph)
            ph_active: return ph_front;
            ph_front:  return ph_sync;
            ph_sync:   return ph_back;
            default:   return ph_active;   // Back porch wraps to active
        endcase
    endfunction

    assign h_end      = (h_pos == phase_last(h_ph, h_cfg_q));
    assign v_end      = (v_pos == phase_last(v_ph, v_cfg_q));
    assign line_step  = pxl_cen && h_end && (h_ph == ph_active);   // Same edge as lhbl fall
    assign frame_wrap = line_step && v_end && (v_ph == ph_back);

    always_comb begin                  // Horizontal machine, one step per enabled pixel
        h_ph_nx  = h_ph;
        h_pos_nx = h_pos;
        if (pxl_cen) begin
            if (h_end) begin
                h_ph_nx  = phase_next(h_ph);
                h_pos_nx = '0;
            end else begin
                h_pos_nx = h_pos + 9'd1;
            end
        end
    end

    always_comb begin                  // Vertical machine, one step per line
        v_ph_nx  = v_ph;
        v_pos_nx = v_pos;
        if (line_step) begin
            if (v_end) begin
                v_ph_nx  = phase_next(v_ph);
                v_pos_nx = '0;
            end else begin
                v_pos_nx = v_pos + 9'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            h_ph   <= ph_front;        // Start of front porch on both axes
            h_pos  <= '0;
            v_ph   <= ph_front;
            v_pos  <= '0;
            raster <= '0;              // Front porch decodes to all low
        end else begin
            h_ph        <= h_ph_nx;
            h_pos       <= h_pos_nx;
            v_ph        <= v_ph_nx;
            v_pos       <= v_pos_nx;
            raster.lhbl <= (h_ph_nx == ph_active);   // Decoded from next state
            raster.hs   <= (h_ph_nx == ph_sync);
            raster.lvbl <= (v_ph_nx == ph_active);
            raster.vs   <= (v_ph_nx == ph_sync);
        end
    end

    // New timing only at the frame boundary, so a frame never mixes two configs
    always_ff @(posedge clk) begin
        if (rst || frame_wrap) begin   // Loaded at reset too, the first frame needs one
            h_cfg_q <= h_cfg;
            v_cfg_q <= v_cfg;
        end
    end

endmodule

`default_nettype wire

// File: hdl/meas_pkg.sv
`default_nettype none

package meas_pkg;

    // Recovered timing of one axis
    typedef struct packed {
        raster_pkg::px_cnt_t total;  // Active length minus one, low byte mirrored on flip
        raster_pkg::len_t    bs_len; // Blank start to sync start
        raster_pkg::len_t    sy_len; // Sync length
        raster_pkg::len_t    sa_len; // Sync end to active start
    } axis_meas_t;

endpackage

`default_nettype wire

// File: hdl/raster_pkg.sv
`default_nettype none

package raster_pkg;

    typedef logic [8:0] px_cnt_t;    // Pixel or line count on one axis
    typedef logic [5:0] len_t;       // Porch or sync length

    // Timing of one axis, fields in raster order
    // Valid when every field is nonzero and the sum stays within 511
    typedef struct packed {
        px_cnt_t active;             // Visible positions
        len_t    front;              // Blanked positions before sync
        len_t    sync;               // Sync width
        len_t    back;               // Blanked positions after sync
    } axis_cfg_t;

    // Raster levels shared by generator and measuring side
    typedef struct packed {
        logic lhbl;                  // High during horizontal active
        logic lvbl;                  // High during vertical active
        logic hs;                    // High during horizontal sync
        logic vs;                    // High during vertical sync
    } video_sync_t;

endpackage

`default_nettype wire
